/* hw/tay_defs.svh */
`ifndef TAY_DEFS_SVH
`define TAY_DEFS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Array size and arithmetic format
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// Number of cores, 1 to 16
`define TAY_NUM_CORES 4

// Fraction bits of samples, coefficients and results
`define TAY_FRAC 16

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Reset release spacing
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define TAY_STAGGER 8 // Cycles between core releases

`endif

/* hw/tay_num_pkg.sv */
`include "tay_defs.svh"

package tay_num_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Fixed point formats
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Q2.16 input sample
	typedef logic signed [`TAY_FRAC+2:0] sample_t;

	// Q11.16 result, also used for x squared
	typedef logic signed [`TAY_FRAC+11:0] result_t;

	// Coefficient and Horner accumulator
	typedef logic signed [`TAY_FRAC+11:0] coef_t;

	// Full product before the shift
	typedef logic signed [47:0] wide_t;

	typedef logic [3:0] tag_t; // Returned with the result

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sine series, odd terms up to x^7
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam coef_t SIN_C0 = 28'sd65536;  // 1
	localparam coef_t SIN_C1 = -28'sd10923; // -1/6
	localparam coef_t SIN_C2 = 28'sd546;    // 1/120
	localparam coef_t SIN_C3 = -28'sd13;    // -1/5040

	// Drop the fraction bits of a product, no rounding
	function automatic result_t fx_trunc(input wide_t p);
		wide_t s;
		s = p >>> `TAY_FRAC;
		return result_t'(s);
	endfunction

endpackage

/* hw/tay_ctl_pkg.sv */
package tay_ctl_pkg;

	typedef logic [3:0] core_idx_t; // Up to 16 cores

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Core sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef enum logic [2:0] {
		IDLE,   // Waiting for start
		SQUARE, // x * x
		HORNER, // Three accumulate steps
		FINAL,  // Times x
		DONE    // Holding result
	} core_state_t;

	// Reset release sequencing
	typedef enum logic {
		COUNT,
		ALL_ON
	} stagger_state_t;

endpackage

/* hw/core_if.sv */
`timescale 1ns/1ps

interface core_if
	import tay_num_pkg::*;
();

	logic    ready; // Core idle and out of reset
	logic    start; // One-cycle launch
	sample_t x;
	tag_t    tag;   // Tag of the sample being launched

	logic    done;  // Level, held until take
	result_t y;
	tag_t    y_tag; // Tag of the held result
	logic    take;  // One-cycle pickup

	modport disp (
		input  ready,
		output start, x, tag
	);

	modport core (
		input  start, x, tag, take,
		output ready, done, y, y_tag
	);

	modport coll (
		input  done, y, y_tag,
		output take
	);

endinterface

/* hw/reset_stagger.sv */
`timescale 1ns/1ps
`include "tay_defs.svh"

module reset_stagger
	import tay_ctl_pkg::*;
(
	input  logic                      clk,
	input  logic                      rst,
	output logic [`TAY_NUM_CORES-1:0] core_rst
);

	localparam int GW = $clog2(`TAY_STAGGER + 1);

	stagger_state_t state;
	logic [GW-1:0]  gap; // Cycles left until the next release

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= COUNT;
			core_rst <= '1;
			gap      <= '0;
		end else if (state == COUNT) begin
			if (gap == '0) begin
				// Zero shifts in at core 0 and moves up one core per release
				core_rst <= core_rst << 1;
				gap      <= GW'(`TAY_STAGGER - 1);
				if ((core_rst << 1) == '0) begin
					state <= ALL_ON; // Last core released
				end
			end else begin
				gap <= gap - GW'(1);
			end
		end
	end

	// A released core stays running until the next global reset
	a_no_reentry: assert property (
		@(posedge clk) disable iff (rst)
		(core_rst & ~$past(core_rst)) == '0
	) else $error("reset_stagger: core put back into reset");

endmodule

/* hw/input_dispatch.sv */
`timescale 1ns/1ps
`include "tay_defs.svh"

module input_dispatch
	import tay_num_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  sample_t in_data,
	input  tag_t    in_tag,
	input  logic    in_valid,
	output logic    in_ready,
	core_if.disp    cores [`TAY_NUM_CORES]
);

	localparam int N = `TAY_NUM_CORES;

	logic [N-1:0] rdy;
	logic [N-1:0] avail;
	logic [N-1:0] grant;
	logic [N-1:0] start_q;
	logic         accept;
	sample_t      x_q;
	tag_t         tag_q;

	for (genvar k = 0; k < N; k++) begin : g_port
		assign rdy[k]         = cores[k].ready;
		assign cores[k].start = start_q[k];
		assign cores[k].x     = x_q;
		assign cores[k].tag   = tag_q;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Pick the lowest ready core
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// A core being started still shows ready for this cycle
	assign avail    = rdy & ~start_q;
	assign grant    = avail & (-avail); // Lowest set bit
	assign in_ready = |avail;
	assign accept   = in_valid & in_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			start_q <= '0;
		end else begin
			start_q <= accept ? grant : '0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			x_q   <= in_data;
			tag_q <= in_tag;
		end
	end

	// A started core must still be idle when it sees start
	a_start_ready: assert property (
		@(posedge clk) disable iff (rst) (start_q & ~rdy) == '0
	) else $error("input_dispatch: start sent to a core that is not ready");

endmodule

/* hw/taylor_core.sv */
`timescale 1ns/1ps
`include "tay_defs.svh"

module taylor_core
	import tay_num_pkg::*;
	import tay_ctl_pkg::*;
(
	input  logic clk,
	input  logic rst,
	core_if.core port
);

	core_state_t state;
	logic [1:0]  step; // Horner step 0..2
	sample_t     x;
	tag_t        tag;
	result_t     x2;
	coef_t       acc;
	result_t     y;
	coef_t       coef;
	wide_t       mul_a;
	wide_t       mul_b;
	wide_t       prod;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Shared multiplier
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		mul_a = wide_t'(x);
		mul_b = wide_t'(x);
		case (state)
			HORNER: begin
				mul_a = wide_t'(acc);
				mul_b = wide_t'(x2);
			end
			FINAL: begin
				mul_a = wide_t'(acc); // acc * x
			end
			default: begin
			end
		endcase
	end

	assign prod = mul_a * mul_b;

	always_comb begin
		case (step)
			2'd0:    coef = SIN_C2;
			2'd1:    coef = SIN_C1;
			default: coef = SIN_C0;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= IDLE;
			step  <= '0;
		end else begin
			case (state)
				IDLE: if (port.start) state <= SQUARE;
				SQUARE: begin
					state <= HORNER;
					step  <= '0;
				end
				HORNER: begin
					step <= step + 2'd1;
					if (step == 2'd2) state <= FINAL;
				end
				FINAL: state <= DONE;
				DONE: if (port.take) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (port.start) begin
					x   <= port.x;
					tag <= port.tag;
				end
			end
			SQUARE: begin
				x2  <= fx_trunc(prod);
				acc <= SIN_C3;
			end
			HORNER: acc <= coef_t'(fx_trunc(prod)) + coef;
			FINAL: y <= fx_trunc(prod);
			default: begin
			end
		endcase
	end

	assign port.ready = ~rst & (state == IDLE);
	assign port.done  = (state == DONE);
	assign port.y     = y;
	assign port.y_tag = tag;

	// Collect only picks up a held result
	a_take_done: assert property (
		@(posedge clk) disable iff (rst) port.take |-> port.done
	) else $error("taylor_core: take without done");

endmodule

/* hw/result_collect.sv */
`timescale 1ns/1ps
`include "tay_defs.svh"

module result_collect
	import tay_num_pkg::*;
	import tay_ctl_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	core_if.coll      cores [`TAY_NUM_CORES],
	output result_t   out_data,
	output tag_t      out_tag,
	output core_idx_t out_core,
	output logic      out_valid
);

	localparam int N = `TAY_NUM_CORES;

	logic [N-1:0] done_v;
	logic [N-1:0] take_v;
	result_t      y_v   [N];
	tag_t         tag_v [N];
	core_idx_t    sel;
	result_t      sel_y;
	tag_t         sel_tag;

	for (genvar k = 0; k < N; k++) begin : g_port
		assign done_v[k]     = cores[k].done;
		assign y_v[k]        = cores[k].y;
		assign tag_v[k]      = cores[k].y_tag;
		assign cores[k].take = take_v[k];
	end

	// Lowest waiting core wins, take clears its done at the next edge
	assign take_v = done_v & (-done_v);

	always_comb begin
		sel     = '0;
		sel_y   = '0;
		sel_tag = '0;
		for (int k = N - 1; k >= 0; k--) begin
			if (done_v[k]) begin
				sel     = core_idx_t'(k);
				sel_y   = y_v[k];
				sel_tag = tag_v[k];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= |done_v;
		end
	end

	always_ff @(posedge clk) begin
		out_data <= sel_y;
		out_tag  <= sel_tag;
		out_core <= sel;
	end

	// A taken core drops done so its result is not sent twice
	a_take_clears: assert property (
		@(posedge clk) disable iff (rst) |take_v |=> (done_v & $past(take_v)) == '0
	) else $error("result_collect: done still high after take");

endmodule

/* hw/taylor_multicore.sv */
`timescale 1ns/1ps
`include "tay_defs.svh"

module taylor_multicore
	import tay_num_pkg::*;
	import tay_ctl_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  sample_t   in_data,
	input  tag_t      in_tag,
	input  logic      in_valid,
	output logic      in_ready,
	output result_t   out_data,
	output tag_t      out_tag,
	output core_idx_t out_core,
	output logic      out_valid
);

	localparam int N = `TAY_NUM_CORES;

	logic [N-1:0] core_rst; // One staggered reset per core

	core_if cores [N] ();

	reset_stagger reset_stagger_i (
		.clk      (clk),
		.rst      (rst),
		.core_rst (core_rst)
	);

	input_dispatch input_dispatch_i (
		.clk      (clk),
		.rst      (rst),
		.in_data  (in_data),
		.in_tag   (in_tag),
		.in_valid (in_valid),
		.in_ready (in_ready),
		.cores    (cores)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Core array
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	for (genvar k = 0; k < N; k++) begin : g_core
		taylor_core taylor_core_i (
			.clk  (clk),
			.rst  (core_rst[k]),
			.port (cores[k])
		);
	end

	result_collect result_collect_i (
		.clk       (clk),
		.rst       (rst),
		.cores     (cores),
		.out_data  (out_data),
		.out_tag   (out_tag),
		.out_core  (out_core),
		.out_valid (out_valid)
	);

endmodule

/* test/tb_taylor_multicore.sv */
`timescale 1ns/1ps
`include "tay_defs.svh"

module tb_taylor_multicore
	import tay_num_pkg::*;
	import tay_ctl_pkg::*;
;

	localparam int WAIT_LIMIT   = 200;
	localparam int STREAM_COUNT = 40;
	localparam int ISO_RANDOM   = 6;
	localparam int RES_BITS     = 28;

	logic      clk;
	logic      rst;
	sample_t   in_data;
	tag_t      in_tag;
	logic      in_valid;
	logic      in_ready;
	result_t   out_data;
	tag_t      out_tag;
	core_idx_t out_core;
	logic      out_valid;

	logic        accept_now;
	logic        iso_mode;   // One sample in flight at a time
	logic        burst_mode; // One sample per core, back to back
	logic        timed_out;
	int          err_count;
	int          acc_count;
	int          out_count;
	int          cyc;        // Edges since rst went low
	tag_t        next_tag;
	logic [31:0] rnd_state;
	longint      exp_val [16];
	logic [15:0] pending;    // Tags accepted and not yet returned

	// Zero, +1.0, -1.0, largest and smallest sample
	sample_t special [5] = '{19'h00000, 19'h10000, 19'h70000, 19'h3ffff, 19'h40000};

	taylor_multicore taylor_multicore_i (
		.clk       (clk),
		.rst       (rst),
		.in_data   (in_data),
		.in_tag    (in_tag),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.out_data  (out_data),
		.out_tag   (out_tag),
		.out_core  (out_core),
		.out_valid (out_valid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	assign accept_now = in_valid & in_ready;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic sample_t random_sample();
		rnd_state = lcg_next(rnd_state);
		return sample_t'(rnd_state[31:13]); // Upper bits, better spread
	endfunction

	function automatic longint to_result(input longint v);
		return (v <<< (64 - RES_BITS)) >>> (64 - RES_BITS); // Wrap to 28 bits
	endfunction

	function automatic longint sin_coef(input int i);
		real v;
		case (i)
			0:       v = 1.0;
			1:       v = -1.0 / 6.0;
			2:       v = 1.0 / 120.0;
			default: v = -1.0 / 5040.0;
		endcase
		return longint'($rtoi($floor(v * (2.0 ** `TAY_FRAC) + 0.5)));
	endfunction

	function automatic longint sine_model(input longint x);
		longint x2;
		longint acc;
		x2  = to_result((x * x) >>> `TAY_FRAC);
		acc = sin_coef(3);
		for (int i = 2; i >= 0; i--) begin
			acc = to_result(to_result((acc * x2) >>> `TAY_FRAC) + sin_coef(i));
		end
		return to_result((acc * x) >>> `TAY_FRAC);
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			cyc       <= 0;
			acc_count <= 0;
			out_count <= 0;
			pending   <= '0;
		end else begin
			cyc <= cyc + 1;
			if (accept_now) begin
				exp_val[in_tag] <= sine_model(longint'(in_data));
				pending[in_tag] <= 1'b1;
				acc_count       <= acc_count + 1;
			end
			if (out_valid) begin
				pending[out_tag] <= 1'b0;
				out_count        <= out_count + 1;
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Checks
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic report_error(input string msg);
		err_count++;
		$display("ERR %0t: %s", $time, msg);
	endtask

	a_reset_idle: assert property (@(posedge clk) $fell(rst) |-> !in_ready && !out_valid)
		else report_error("in_ready or out_valid high right after reset");
	a_first_ready: assert property (@(posedge clk) $fell(rst) |=> in_ready)
		else report_error("in_ready not high one cycle after reset");
	a_value: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> longint'(out_data) == exp_val[out_tag])
		else report_error($sformatf("tag %0d gave %0d, expected %0d",
			out_tag, out_data, exp_val[out_tag]));
	a_once: assert property (@(posedge clk) disable iff (rst) out_valid |-> pending[out_tag])
		else report_error($sformatf("tag %0d returned without a pending sample", out_tag));
	a_tag_free: assert property (@(posedge clk) disable iff (rst)
		accept_now |-> !pending[in_tag])
		else report_error($sformatf("tag %0d accepted while still in flight", in_tag));
	a_latency: assert property (@(posedge clk) disable iff (rst)
		iso_mode && $past(accept_now, 8) |->
			out_valid && out_core == '0 && out_tag == $past(in_tag, 8))
		else report_error("lone sample not returned by core 0 after 7 cycles");
	a_no_early: assert property (@(posedge clk) disable iff (rst)
		iso_mode && out_valid |-> $past(accept_now, 8))
		else report_error("lone sample returned with wrong latency");
	a_stagger: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> cyc >= (`TAY_STAGGER) * int'(out_core) + 9)
		else report_error($sformatf("core %0d returned a result before its release", out_core));
	a_order: assert property (@(posedge clk) disable iff (rst)
		burst_mode && out_valid && $past(out_valid) |->
			out_core == $past(out_core) + core_idx_t'(1))
		else report_error($sformatf("core %0d out of ascending order", out_core));

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Stimulus
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// Holds in_valid until the sample is taken, in_valid stays high afterwards
	task automatic send_sample(input sample_t x);
		int   n;
		logic got;
		n   = 0;
		got = 1'b0;
		in_data  <= x;
		in_tag   <= next_tag;
		in_valid <= 1'b1;
		while (!got && n < WAIT_LIMIT) begin
			@(posedge clk);
			got = in_ready;
			n++;
		end
		if (got) begin
			next_tag = next_tag + 4'd1;
		end else begin
			$display("timeout: sample with tag %0d not accepted in %0d cycles",
				next_tag, WAIT_LIMIT);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (out_count != acc_count && n < WAIT_LIMIT);
		if (out_count != acc_count) begin
			$display("timeout: %0d results still missing after %0d cycles",
				acc_count - out_count, WAIT_LIMIT);
			timed_out = 1'b1;
		end
	endtask

	initial begin
		rst        = 1'b1;
		in_valid   = 1'b0;
		in_data    = '0;
		in_tag     = '0;
		iso_mode   = 1'b0;
		burst_mode = 1'b0;
		timed_out  = 1'b0;
		err_count  = 0;
		next_tag   = '0;
		rnd_state  = 32'h0408_8c16;
		repeat (2) @(posedge clk);
		rst <= 1'b0;

		// Offered every cycle while the cores come out of reset
		for (int i = 0; i < STREAM_COUNT && !timed_out; i++) begin
			send_sample(random_sample());
		end
		in_valid <= 1'b0;
		if (!timed_out) wait_drain();

		iso_mode <= 1'b1;
		for (int i = 0; i < 5 + ISO_RANDOM && !timed_out; i++) begin
			send_sample(i < 5 ? special[i] : random_sample());
			in_valid <= 1'b0;
			if (!timed_out) wait_drain();
		end
		iso_mode <= 1'b0;

		burst_mode <= 1'b1;
		for (int i = 0; i < `TAY_NUM_CORES && !timed_out; i++) begin
			send_sample(random_sample());
		end
		in_valid <= 1'b0;
		if (!timed_out) wait_drain();
		burst_mode <= 1'b0;
		repeat (4) @(posedge clk);

		a_all_out: assert (out_count == acc_count && pending == '0) else begin
			err_count++;
			$display("result count %0d does not match acceptance count %0d",
				out_count, acc_count);
		end
		$display("accepted %0d, results %0d, errors %0d", acc_count, out_count, err_count);
		if (err_count == 0 && !timed_out) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* files.f */
+incdir+hw
hw/tay_num_pkg.sv
hw/tay_ctl_pkg.sv
hw/core_if.sv
hw/reset_stagger.sv
hw/input_dispatch.sv
hw/taylor_core.sv
hw/result_collect.sv
hw/taylor_multicore.sv
test/tb_taylor_multicore.sv

/* Makefile */
# Verilator build and run for the Taylor series multicore

VERILATOR ?= verilator
TOP       ?= tb_taylor_multicore
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG := TEST RESULT: FAIL
PASS_MSG := TEST RESULT: PASS
BIN      := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no result line in $(LOG)"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
